/* source/soc_pkg.sv */
package soc_pkg;

  // master request, valid travels alongside
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;  // zero for a read
  } bus_req_t;

  // value doubles as slave index
  typedef enum logic [1:0] {
    SEL_CLINT = 2'd0,
    SEL_PRINT = 2'd1,
    SEL_BRAM  = 2'd2
  } slave_sel_t;

  typedef struct packed {
    slave_sel_t  sel;
    logic [31:0] offset;  // address minus slave base
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } dec_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } bus_rsp_t;

  localparam int NUM_SLAVES = 3;

  // default memory map
  localparam logic [31:0] DEF_CLINT_BASE = 32'h0200_0000;
  localparam logic [31:0] DEF_CLINT_SIZE = 32'h0001_0000;
  localparam logic [31:0] DEF_PRINT_BASE = 32'h1000_0000;
  localparam logic [31:0] DEF_PRINT_SIZE = 32'h0000_1000;
  localparam logic [31:0] DEF_BRAM_BASE  = 32'h8000_0000;
  localparam logic [31:0] DEF_BRAM_SIZE  = 32'h0000_0400;

endpackage

/* source/addr_decode.sv */
module addr_decode
  import soc_pkg::*;
#(
  parameter logic [31:0] CLINT_BASE = DEF_CLINT_BASE,
  parameter logic [31:0] CLINT_SIZE = DEF_CLINT_SIZE,
  parameter logic [31:0] PRINT_BASE = DEF_PRINT_BASE,
  parameter logic [31:0] PRINT_SIZE = DEF_PRINT_SIZE,
  parameter logic [31:0] BRAM_BASE  = DEF_BRAM_BASE,
  parameter logic [31:0] BRAM_SIZE  = DEF_BRAM_SIZE
)
(
  input  logic     imem_valid_i,
  input  bus_req_t imem_req_i,
  input  logic     dmem_valid_i,
  input  bus_req_t dmem_req_i,
  output dec_req_t imem_dec_o,
  output dec_req_t dmem_dec_o
);

  // subtract first so a range at the top of the map cannot overflow
  function automatic logic in_range(logic [31:0] addr, logic [31:0] base, logic [31:0] size);
    return (addr >= base) && ((addr - base) < size);
  endfunction

  function automatic dec_req_t decode(logic valid, bus_req_t req);
    dec_req_t dec;
    dec = '{sel: SEL_BRAM, offset: '0, wdata: '0, wstrb: '0};
    if (valid) begin
      dec.wdata = req.wdata;
      dec.wstrb = req.wstrb;
      if (in_range(req.addr, CLINT_BASE, CLINT_SIZE)) begin
        dec.sel    = SEL_CLINT;
        dec.offset = req.addr - CLINT_BASE;
      end else if (in_range(req.addr, PRINT_BASE, PRINT_SIZE)) begin
        dec.sel    = SEL_PRINT;
        dec.offset = req.addr - PRINT_BASE;
      end else begin
        // ram range and unmapped addresses alike
        dec.sel    = SEL_BRAM;
        dec.offset = req.addr - BRAM_BASE;
      end
    end
    return dec;
  endfunction

  assign imem_dec_o = decode(imem_valid_i, imem_req_i);
  assign dmem_dec_o = decode(dmem_valid_i, dmem_req_i);

endmodule

/* source/slave_port.sv */
module slave_port
  import soc_pkg::*;
#(
  parameter slave_sel_t SLAVE_ID = SEL_CLINT
)
(
  input  logic        clk,
  input  logic        rst,
  input  logic        imem_valid_i,
  input  logic        dmem_valid_i,
  input  dec_req_t    imem_dec_i,
  input  dec_req_t    dmem_dec_i,
  input  logic        slv_ready_i,
  input  logic [31:0] slv_rdata_i,
  output logic        slv_valid_o,
  output bus_req_t    slv_req_o,
  output bus_rsp_t    imem_rsp_o,
  output bus_rsp_t    dmem_rsp_o
);

  localparam logic OWN_I = 1'b0;
  localparam logic OWN_D = 1'b1;

  logic     busy;   // high in the slave's ready cycle
  logic     owner;
  logic     imem_hit;
  logic     dmem_hit;
  logic     imem_take;
  logic     dmem_take;
  dec_req_t grant;

  assign imem_hit = imem_valid_i && (imem_dec_i.sel == SLAVE_ID);
  assign dmem_hit = dmem_valid_i && (dmem_dec_i.sel == SLAVE_ID);

  // owner still holds valid while its ready is out, skip that stale request
  assign dmem_take = dmem_hit && !(busy && owner == OWN_D);
  assign imem_take = imem_hit && !(busy && owner == OWN_I) && !dmem_take;  // data wins

  assign grant       = dmem_take ? dmem_dec_i : imem_dec_i;
  assign slv_valid_o = dmem_take || imem_take;
  assign slv_req_o   = '{addr: grant.offset, wdata: grant.wdata, wstrb: grant.wstrb};

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      busy  <= 1'b0;
      owner <= OWN_I;
    end else begin
      busy <= slv_valid_o;
      if (slv_valid_o) begin
        owner <= dmem_take ? OWN_D : OWN_I;
      end
    end
  end

  always_comb begin
    imem_rsp_o = '0;
    dmem_rsp_o = '0;
    if (busy && slv_ready_i) begin
      if (owner == OWN_D) begin
        dmem_rsp_o = '{rdata: slv_rdata_i, ready: 1'b1};
      end else begin
        imem_rsp_o = '{rdata: slv_rdata_i, ready: 1'b1};
      end
    end
  end

endmodule

/* source/resp_return.sv */
module resp_return
  import soc_pkg::*;
(
  input  bus_rsp_t port_imem_rsp_i [NUM_SLAVES],
  input  bus_rsp_t port_dmem_rsp_i [NUM_SLAVES],
  output bus_rsp_t imem_rsp_o,
  output bus_rsp_t dmem_rsp_o
);

  // ports zero their idle responses, at most one owns a master
  always_comb begin
    imem_rsp_o = '0;
    dmem_rsp_o = '0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      imem_rsp_o.ready |= port_imem_rsp_i[s].ready;
      imem_rsp_o.rdata |= port_imem_rsp_i[s].rdata;
      dmem_rsp_o.ready |= port_dmem_rsp_i[s].ready;
      dmem_rsp_o.rdata |= port_dmem_rsp_i[s].rdata;
    end
  end

endmodule

/* source/bram.sv */
module bram
  import soc_pkg::*;
#(
  parameter int BRAM_WORDS = 256
)
(
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  input  bus_req_t    req_i,
  output logic        ready_o,
  output logic [31:0] rdata_o
);

  localparam int IDX_W = (BRAM_WORDS > 1) ? $clog2(BRAM_WORDS) : 1;

  logic [31:0]      mem [BRAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             ready_q;
  logic [31:0]      rdata_q;

  // word index wraps at the depth
  assign idx = IDX_W'((req_i.addr >> 2) % BRAM_WORDS);

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem[idx];  // old word on a write
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rdata_q;

endmodule

/* source/print.sv */
module print
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  input  bus_req_t    req_i,
  output logic        ready_o,
  output logic [31:0] rdata_o,
  output logic        char_valid_o,
  output logic [7:0]  char_o
);

  logic        wr_char;
  logic        ready_q;
  logic        char_valid_q;
  logic [7:0]  char_q;
  logic [31:0] char_count;
  logic [31:0] rdata_q;

  assign wr_char = valid_i && (req_i.wstrb != 4'b0) && (req_i.addr == 32'h0);

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      ready_q      <= 1'b0;
      char_valid_q <= 1'b0;
      char_count   <= '0;
    end else begin
      ready_q      <= valid_i;
      char_valid_q <= wr_char;
      if (wr_char) begin
        char_count <= char_count + 32'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_char) begin
      char_q <= req_i.wdata[7:0];
    end
    if (valid_i) begin
      rdata_q <= char_count;  // any offset reads the count
    end
  end

  assign ready_o      = ready_q;
  assign rdata_o      = rdata_q;
  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;

endmodule

/* source/clint.sv */
module clint
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        rtc_i,
  input  logic        valid_i,
  input  bus_req_t    req_i,
  output logic        ready_o,
  output logic [31:0] rdata_o,
  output logic        msip_o,
  output logic        mtip_o,
  output logic [63:0] mtime_o
);

  localparam logic [31:0] MSIP_OFS        = 32'h0000_0000;
  localparam logic [31:0] MTIMECMP_LO_OFS = 32'h0000_4000;
  localparam logic [31:0] MTIMECMP_HI_OFS = 32'h0000_4004;
  localparam logic [31:0] MTIME_LO_OFS    = 32'h0000_BFF8;
  localparam logic [31:0] MTIME_HI_OFS    = 32'h0000_BFFC;

  logic [1:0]  rtc_sync;
  logic        rtc_prev;
  logic        rtc_rise;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        msip;
  logic        ready_q;
  logic [31:0] rd_mux;
  logic [31:0] rdata_q;

  assign rtc_rise = rtc_sync[1] && !rtc_prev;

  always_comb begin
    case (req_i.addr)
      MSIP_OFS:        rd_mux = {31'b0, msip};
      MTIMECMP_LO_OFS: rd_mux = mtimecmp[31:0];
      MTIMECMP_HI_OFS: rd_mux = mtimecmp[63:32];
      MTIME_LO_OFS:    rd_mux = mtime[31:0];
      MTIME_HI_OFS:    rd_mux = mtime[63:32];
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      rtc_sync <= 2'b0;
      rtc_prev <= 1'b0;
      mtime    <= '0;
      mtimecmp <= '1;  // keeps mtip low out of reset
      msip     <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      rtc_sync <= {rtc_sync[0], rtc_i};
      rtc_prev <= rtc_sync[1];
      ready_q  <= valid_i;
      if (rtc_rise) begin
        mtime <= mtime + 64'd1;
      end
      // any strobe writes the whole word
      if (valid_i && req_i.wstrb != 4'b0) begin
        case (req_i.addr)
          MSIP_OFS:        msip <= req_i.wdata[0];
          MTIMECMP_LO_OFS: mtimecmp[31:0] <= req_i.wdata;
          MTIMECMP_HI_OFS: mtimecmp[63:32] <= req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      rdata_q <= rd_mux;
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rdata_q;
  assign msip_o  = msip;
  assign mtip_o  = (mtime >= mtimecmp);
  assign mtime_o = mtime;

endmodule

/* source/soc_bus.sv */
module soc_bus
  import soc_pkg::*;
#(
  parameter logic [31:0] CLINT_BASE = DEF_CLINT_BASE,
  parameter logic [31:0] CLINT_SIZE = DEF_CLINT_SIZE,
  parameter logic [31:0] PRINT_BASE = DEF_PRINT_BASE,
  parameter logic [31:0] PRINT_SIZE = DEF_PRINT_SIZE,
  parameter logic [31:0] BRAM_BASE  = DEF_BRAM_BASE,
  parameter logic [31:0] BRAM_SIZE  = DEF_BRAM_SIZE,
  parameter int          BRAM_WORDS = 256
)
(
  input  logic        clk,
  input  logic        rst,
  input  logic        rtc_i,
  input  logic        imem_valid_i,
  input  bus_req_t    imem_req_i,
  input  logic        dmem_valid_i,
  input  bus_req_t    dmem_req_i,
  output bus_rsp_t    imem_rsp_o,
  output bus_rsp_t    dmem_rsp_o,
  output logic        char_valid_o,
  output logic [7:0]  char_o,
  output logic        msip_o,
  output logic        mtip_o,
  output logic [63:0] mtime_o
);

  dec_req_t    imem_dec;
  dec_req_t    dmem_dec;
  logic        slv_valid [NUM_SLAVES];
  bus_req_t    slv_req [NUM_SLAVES];
  logic        slv_ready [NUM_SLAVES];
  logic [31:0] slv_rdata [NUM_SLAVES];
  bus_rsp_t    port_imem_rsp [NUM_SLAVES];
  bus_rsp_t    port_dmem_rsp [NUM_SLAVES];

  addr_decode #(
    .CLINT_BASE (CLINT_BASE),
    .CLINT_SIZE (CLINT_SIZE),
    .PRINT_BASE (PRINT_BASE),
    .PRINT_SIZE (PRINT_SIZE),
    .BRAM_BASE  (BRAM_BASE),
    .BRAM_SIZE  (BRAM_SIZE)
  ) decode_comp (
    .imem_valid_i (imem_valid_i),
    .imem_req_i   (imem_req_i),
    .dmem_valid_i (dmem_valid_i),
    .dmem_req_i   (dmem_req_i),
    .imem_dec_o   (imem_dec),
    .dmem_dec_o   (dmem_dec)
  );

  // one port per slave, index follows slave_sel_t
  for (genvar g = 0; g < NUM_SLAVES; g++) begin : g_port
    slave_port #(
      .SLAVE_ID (slave_sel_t'(g))
    ) port_comp (
      .clk          (clk),
      .rst          (rst),
      .imem_valid_i (imem_valid_i),
      .dmem_valid_i (dmem_valid_i),
      .imem_dec_i   (imem_dec),
      .dmem_dec_i   (dmem_dec),
      .slv_ready_i  (slv_ready[g]),
      .slv_rdata_i  (slv_rdata[g]),
      .slv_valid_o  (slv_valid[g]),
      .slv_req_o    (slv_req[g]),
      .imem_rsp_o   (port_imem_rsp[g]),
      .dmem_rsp_o   (port_dmem_rsp[g])
    );
  end

  resp_return return_comp (
    .port_imem_rsp_i (port_imem_rsp),
    .port_dmem_rsp_i (port_dmem_rsp),
    .imem_rsp_o      (imem_rsp_o),
    .dmem_rsp_o      (dmem_rsp_o)
  );

  bram #(
    .BRAM_WORDS (BRAM_WORDS)
  ) bram_comp (
    .clk     (clk),
    .rst     (rst),
    .valid_i (slv_valid[SEL_BRAM]),
    .req_i   (slv_req[SEL_BRAM]),
    .ready_o (slv_ready[SEL_BRAM]),
    .rdata_o (slv_rdata[SEL_BRAM])
  );

  print print_comp (
    .clk          (clk),
    .rst          (rst),
    .valid_i      (slv_valid[SEL_PRINT]),
    .req_i        (slv_req[SEL_PRINT]),
    .ready_o      (slv_ready[SEL_PRINT]),
    .rdata_o      (slv_rdata[SEL_PRINT]),
    .char_valid_o (char_valid_o),
    .char_o       (char_o)
  );

  clint clint_comp (
    .clk     (clk),
    .rst     (rst),
    .rtc_i   (rtc_i),
    .valid_i (slv_valid[SEL_CLINT]),
    .req_i   (slv_req[SEL_CLINT]),
    .ready_o (slv_ready[SEL_CLINT]),
    .rdata_o (slv_rdata[SEL_CLINT]),
    .msip_o  (msip_o),
    .mtip_o  (mtip_o),
    .mtime_o (mtime_o)
  );

endmodule

/* verif/soc_bus_checker.sv */
module soc_bus_checker
  import soc_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     imem_valid_i,
  input logic     dmem_valid_i,
  input bus_rsp_t imem_rsp_i,
  input bus_rsp_t dmem_rsp_i,
  input logic     msip_i,
  input logic     mtip_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;  // read by the testbench at the end

  imem_ready_needs_valid: assert property (@(posedge clk) disable iff (rst == 0)
    imem_rsp_i.ready |-> imem_valid_i)
    else begin
      fail_count++;
      $error("imem ready seen without imem valid");
    end

  dmem_ready_needs_valid: assert property (@(posedge clk) disable iff (rst == 0)
    dmem_rsp_i.ready |-> dmem_valid_i)
    else begin
      fail_count++;
      $error("dmem ready seen without dmem valid");
    end

  // ready is a single-cycle pulse
  imem_ready_pulse: assert property (@(posedge clk) disable iff (rst == 0)
    imem_rsp_i.ready |=> !imem_rsp_i.ready)
    else begin
      fail_count++;
      $error("imem ready high for two cycles");
    end

  dmem_ready_pulse: assert property (@(posedge clk) disable iff (rst == 0)
    dmem_rsp_i.ready |=> !dmem_rsp_i.ready)
    else begin
      fail_count++;
      $error("dmem ready high for two cycles");
    end

  reset_state: assert property (@(posedge clk)
    (rst == 0) |=> !imem_rsp_i.ready && !dmem_rsp_i.ready && !msip_i && !mtip_i)
    else begin
      fail_count++;
      $error("outputs not cleared by reset");
    end

endmodule

bind soc_bus soc_bus_checker checks (
  .clk          (clk),
  .rst          (rst),
  .imem_valid_i (imem_valid_i),
  .dmem_valid_i (dmem_valid_i),
  .imem_rsp_i   (imem_rsp_o),
  .dmem_rsp_i   (dmem_rsp_o),
  .msip_i       (msip_o),
  .mtip_i       (mtip_o)
);

/* verif/soc_bus_tb.sv */
module soc_bus_tb
  import soc_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 20;
  localparam int DEPTH   = 256;
  localparam int NUM_OPS = 31;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_BOTH, OP_TICK} op_kind_t;

  typedef struct packed {
    op_kind_t    kind;
    logic        use_imem;  // master of a single op
    logic        rnd;       // wdata from the lcg
    logic [31:0] addr;
    logic [31:0] wdata;     // rtc pulse count for OP_TICK
    logic [3:0]  wstrb;
  } op_t;

  logic        clk;
  logic        rst;
  logic        rtc_i;
  logic        imem_valid_i;
  bus_req_t    imem_req_i;
  logic        dmem_valid_i;
  bus_req_t    dmem_req_i;
  bus_rsp_t    imem_rsp_o;
  bus_rsp_t    dmem_rsp_o;
  logic        char_valid_o;
  logic [7:0]  char_o;
  logic        msip_o;
  logic        mtip_o;
  logic [63:0] mtime_o;

  int          errors = 0;
  logic [31:0] lcg_state = 32'd24;
  logic [31:0] ram_model [DEPTH];
  logic [31:0] chars_written = '0;
  logic [7:0]  char_exp;
  logic        char_due;
  int          char_pulses;
  logic [7:0]  char_last;
  logic        msip_exp = 1'b0;
  logic [63:0] cmp_exp = '1;
  logic [63:0] ticks = '0;

  op_t ops [NUM_OPS] = '{
    '{OP_WR, 1'b0, 1'b1, 32'h8000_0000, 32'h0, 4'hF},
    '{OP_WR, 1'b0, 1'b1, 32'h8000_0004, 32'h0, 4'hF},
    '{OP_WR, 1'b0, 1'b1, 32'h8000_0004, 32'h0, 4'h5},
    '{OP_WR, 1'b0, 1'b1, 32'h8000_0008, 32'h0, 4'hF},
    '{OP_WR, 1'b0, 1'b1, 32'h8000_0008, 32'h0, 4'h2},
    '{OP_RD, 1'b0, 1'b0, 32'h8000_0000, 32'h0, 4'h0},
    '{OP_RD, 1'b1, 1'b0, 32'h8000_0004, 32'h0, 4'h0},
    '{OP_RD, 1'b0, 1'b0, 32'h8000_0008, 32'h0, 4'h0},
    '{OP_RD, 1'b1, 1'b0, 32'h8000_0000, 32'h0, 4'h0},
    '{OP_WR, 1'b0, 1'b1, 32'h8000_0410, 32'h0, 4'hF},  // past the ram range
    '{OP_RD, 1'b0, 1'b0, 32'h8000_0010, 32'h0, 4'h0},
    '{OP_WR, 1'b0, 1'b1, 32'h4000_0020, 32'h0, 4'hF},  // unmapped
    '{OP_RD, 1'b1, 1'b0, 32'h8000_0020, 32'h0, 4'h0},
    '{OP_WR, 1'b0, 1'b0, 32'h1000_0000, 32'h0000_0041, 4'hF},
    '{OP_WR, 1'b0, 1'b0, 32'h1000_0000, 32'h1234_566B, 4'h1},
    '{OP_RD, 1'b0, 1'b0, 32'h1000_0000, 32'h0, 4'h0},
    '{OP_WR, 1'b1, 1'b0, 32'h1000_0000, 32'h0000_000A, 4'hF},
    '{OP_RD, 1'b1, 1'b0, 32'h1000_0008, 32'h0, 4'h0},
    '{OP_WR, 1'b0, 1'b0, 32'h0200_0000, 32'h1, 4'hF},
    '{OP_RD, 1'b0, 1'b0, 32'h0200_0000, 32'h0, 4'h0},
    '{OP_WR, 1'b0, 1'b0, 32'h0200_0000, 32'h0, 4'hF},
    '{OP_WR, 1'b0, 1'b0, 32'h0200_4000, 32'h5, 4'hF},
    '{OP_WR, 1'b0, 1'b0, 32'h0200_4004, 32'h0, 4'hF},
    '{OP_RD, 1'b0, 1'b0, 32'h0200_4000, 32'h0, 4'h0},
    '{OP_TICK, 1'b0, 1'b0, 32'h0, 32'd3, 4'h0},
    '{OP_RD, 1'b0, 1'b0, 32'h0200_BFF8, 32'h0, 4'h0},
    '{OP_TICK, 1'b0, 1'b0, 32'h0, 32'd2, 4'h0},
    '{OP_RD, 1'b1, 1'b0, 32'h0200_BFF8, 32'h0, 4'h0},
    '{OP_RD, 1'b0, 1'b0, 32'h0200_BFFC, 32'h0, 4'h0},
    '{OP_BOTH, 1'b0, 1'b0, 32'h8000_0000, 32'h0, 4'h0},
    '{OP_BOTH, 1'b0, 1'b0, 32'h8000_0004, 32'h0, 4'h0}
  };

  soc_bus UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic in_map(logic [31:0] addr, logic [31:0] base, logic [31:0] size);
    return (addr >= base) && ({1'b0, addr} < {1'b0, base} + {1'b0, size});
  endfunction

  // ram also catches every unmapped address
  function automatic int ram_index(logic [31:0] addr);
    logic [31:0] ofs;
    ofs = addr - DEF_BRAM_BASE;
    return int'((ofs >> 2) % DEPTH);
  endfunction

  function automatic logic [31:0] model_read(logic [31:0] addr);
    logic [31:0] ofs;
    ofs = addr - DEF_CLINT_BASE;
    if (in_map(addr, DEF_CLINT_BASE, DEF_CLINT_SIZE)) begin
      case (ofs)
        32'h0000: return {31'b0, msip_exp};
        32'h4000: return cmp_exp[31:0];
        32'h4004: return cmp_exp[63:32];
        32'hBFF8: return ticks[31:0];
        32'hBFFC: return ticks[63:32];
        default:  return 32'h0;
      endcase
    end else if (in_map(addr, DEF_PRINT_BASE, DEF_PRINT_SIZE)) begin
      return chars_written;
    end
    return ram_model[ram_index(addr)];
  endfunction

  task automatic model_write(logic [31:0] addr, logic [31:0] wdata, logic [3:0] wstrb);
    logic [31:0] ofs;
    int          idx;
    ofs = addr - DEF_CLINT_BASE;
    idx = ram_index(addr);
    if (in_map(addr, DEF_CLINT_BASE, DEF_CLINT_SIZE)) begin
      if (wstrb != 4'h0) begin
        case (ofs)
          32'h0000: msip_exp = wdata[0];
          32'h4000: cmp_exp[31:0] = wdata;
          32'h4004: cmp_exp[63:32] = wdata;
          default: ;
        endcase
      end
    end else if (in_map(addr, DEF_PRINT_BASE, DEF_PRINT_SIZE)) begin
      if (addr == DEF_PRINT_BASE && wstrb != 4'h0) begin
        chars_written = chars_written + 32'd1;
        char_exp      = wdata[7:0];
        char_due      = 1'b1;
      end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) ram_model[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic check_word(string name, bus_rsp_t rsp, logic [31:0] exp);
    if (rsp.rdata !== exp) begin
      errors++;
      $display("Fail %s expected %08h got %08h", name, exp, rsp.rdata);
    end
  endtask

  task automatic check_char(string name, logic [7:0] act, logic [7:0] exp);
    if (act !== exp) begin
      errors++;
      $display("Fail %s expected %02h got %02h", name, exp, act);
    end
  endtask

  task automatic check_time(string name, logic [63:0] act, logic [63:0] exp);
    if (act !== exp) begin
      errors++;
      $display("Fail %s expected %016h got %016h", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic act, logic exp);
    if (act !== exp) begin
      errors++;
      $display("Fail %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_reset_state();
    check_flag("imem_rsp_o.ready", imem_rsp_o.ready, 1'b0);
    check_flag("dmem_rsp_o.ready", dmem_rsp_o.ready, 1'b0);
    check_flag("char_valid_o", char_valid_o, 1'b0);
    check_flag("msip_o", msip_o, 1'b0);
    check_flag("mtip_o", mtip_o, 1'b0);
    check_time("mtime_o", mtime_o, 64'h0);
  endtask

  // called on a falling edge, returns on one
  task automatic run_bus(input logic use_i, input logic use_d, input bus_req_t ireq,
                         input bus_req_t dreq, output bus_rsp_t irsp, output bus_rsp_t drsp,
                         output int ilat, output int dlat);
    int   cyc;
    logic i_wait;
    logic d_wait;
    i_wait       = use_i;
    d_wait       = use_d;
    ilat         = 0;
    dlat         = 0;
    irsp         = '0;
    drsp         = '0;
    imem_valid_i = use_i;
    imem_req_i   = ireq;
    dmem_valid_i = use_d;
    dmem_req_i   = dreq;
    cyc          = 0;
    while ((i_wait || d_wait) && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
      if (!i_wait) imem_valid_i = 1'b0;  // ready cycle is over
      if (!d_wait) dmem_valid_i = 1'b0;
      if (char_valid_o) begin
        char_pulses++;
        char_last = char_o;
      end
      if (i_wait && imem_rsp_o.ready) begin
        irsp   = imem_rsp_o;
        ilat   = cyc;
        i_wait = 1'b0;
      end
      if (d_wait && dmem_rsp_o.ready) begin
        drsp   = dmem_rsp_o;
        dlat   = cyc;
        d_wait = 1'b0;
      end
    end
    if (i_wait || d_wait) begin
      errors++;
      $display("timeout: no ready after %0d cycles at %08h", TIMEOUT,
               use_d ? dreq.addr : ireq.addr);
    end
    @(negedge clk);
    if (char_valid_o) char_pulses++;
    imem_valid_i = 1'b0;
    dmem_valid_i = 1'b0;
  endtask

  // slow rtc, each pulse is well past the synchronizer
  task automatic pulse_rtc(int n);
    repeat (n) begin
      rtc_i = 1'b1;
      repeat (4) @(negedge clk);
      rtc_i = 1'b0;
      repeat (4) @(negedge clk);
      ticks = ticks + 64'd1;
    end
  endtask

  initial begin
    op_t         op;
    bus_req_t    ireq;
    bus_req_t    dreq;
    bus_rsp_t    irsp;
    bus_rsp_t    drsp;
    int          ilat;
    int          dlat;
    logic [31:0] exp_i;
    logic [31:0] exp_d;
    rst          = 1'b0;
    rtc_i        = 1'b0;
    imem_valid_i = 1'b0;
    imem_req_i   = '0;
    dmem_valid_i = 1'b0;
    dmem_req_i   = '0;
    for (int c = 0; c < 8; c++) begin
      @(negedge clk);
      check_reset_state();
    end
    rst = 1'b1;
    @(negedge clk);
    check_reset_state();

    for (int k = 0; k < NUM_OPS; k++) begin
      op = ops[k];
      if (op.rnd) op.wdata = lcg_next();
      ireq        = '{addr: op.addr, wdata: op.wdata, wstrb: op.wstrb};
      dreq        = ireq;
      char_due    = 1'b0;
      char_pulses = 0;
      case (op.kind)
        OP_TICK: pulse_rtc(int'(op.wdata));
        OP_BOTH: begin
          ireq.addr = op.addr + 32'd4;
          exp_i     = model_read(ireq.addr);
          exp_d     = model_read(dreq.addr);
          run_bus(1'b1, 1'b1, ireq, dreq, irsp, drsp, ilat, dlat);
          check_word("imem_rsp_o.rdata", irsp, exp_i);
          check_word("dmem_rsp_o.rdata", drsp, exp_d);
          if (dlat != 1 || ilat != 2) begin
            errors++;
            $display("conflict order wrong: dmem ready after %0d, imem after %0d cycles",
                     dlat, ilat);
          end
        end
        default: begin
          exp_i = model_read(op.addr);
          run_bus(op.use_imem, !op.use_imem, ireq, dreq, irsp, drsp, ilat, dlat);
          if (op.kind == OP_WR) model_write(op.addr, op.wdata, op.wstrb);
          if (op.kind == OP_RD && op.use_imem) check_word("imem_rsp_o.rdata", irsp, exp_i);
          if (op.kind == OP_RD && !op.use_imem) check_word("dmem_rsp_o.rdata", drsp, exp_i);
          if (ilat > 1 || dlat > 1) begin
            errors++;
            $display("ready came late at %08h, expected one cycle after valid", op.addr);
          end
        end
      endcase
      if (char_due) begin
        if (char_pulses != 1) begin
          errors++;
          $display("expected one char_valid_o pulse, saw %0d", char_pulses);
        end
        check_char("char_o", char_last, char_exp);
      end else if (char_pulses != 0) begin
        errors++;
        $display("char_valid_o pulsed without a print write");
      end
      check_flag("msip_o", msip_o, msip_exp);
      check_flag("mtip_o", mtip_o, ticks >= cmp_exp);
      check_time("mtime_o", mtime_o, ticks);
    end

    $display("run done: %0d errors, %0d assertion failures", errors, UUT.checks.fail_count);
    if (errors == 0 && UUT.checks.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* soc_bus.f */
source/soc_pkg.sv
source/addr_decode.sv
source/slave_port.sv
source/resp_return.sv
source/bram.sv
source/print.sv
source/clint.sv
source/soc_bus.sv
verif/soc_bus_checker.sv
verif/soc_bus_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module soc_bus_tb -f soc_bus.f -o soc_bus_sim
status=0
./obj_dir/soc_bus_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "CHECKS FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
